/* tb.f */
+incdir+design
design/core_pipe_reg.sv
design/core_register_file.sv
design/core_isa_pkg.sv
design/core_pipe_pkg.sv
design/core_if_stage.sv
design/core_id_stage.sv
design/core_ex_stage.sv
design/core_top.sv
bench/core_tb.sv

/* Makefile */
.PHONY: all run lint clean

all: run

obj_dir/Vcore_tb: tb.f design/*.sv design/*.svh bench/*.sv
	verilator --binary --timing -f tb.f --top-module core_tb -o Vcore_tb

run: obj_dir/Vcore_tb
	./obj_dir/Vcore_tb

lint:
	verilator --lint-only --timing -f tb.f --top-module core_tb

clean:
	rm -rf obj_dir

/* bench/core_tb.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module core_tb;

  localparam logic [`CORE_XLEN-1:0] BOOT_ADDR = 32'h0000_1000;
  localparam int SEED          = 63140;
  localparam int STORE_TIMEOUT = 300;
  localparam int FETCH_TIMEOUT = 300;
  // NOP fetches past the program end before the final store count
  localparam int DRAIN_WORDS   = 8;
  // LOAD major opcode, not part of the kept subset
  localparam logic [6:0] OPC_LOAD = 7'b000_0011;

  logic                  clk_i          = 1'b0;
  logic                  rst_n_i;
  logic                  fetch_enable_i;
  logic [`CORE_XLEN-1:0] boot_addr_i;
  logic                  instr_req_o;
  logic                  instr_gnt_i    = 1'b0;
  logic                  instr_rvalid_i = 1'b0;
  logic [`CORE_XLEN-1:0] instr_addr_o;
  logic [`CORE_XLEN-1:0] instr_rdata_i  = `CORE_NOP;
  logic                  data_req_o;
  logic                  data_gnt_i     = 1'b0;
  logic [`CORE_XLEN-1:0] data_addr_o;
  logic [`CORE_XLEN-1:0] data_wdata_o;

  // Program, expected stores and observed stores
  logic [31:0] prog_q       [$];
  logic [31:0] exp_addr_q   [$];
  logic [31:0] exp_data_q   [$];
  logic [31:0] store_addr_q [$];
  logic [31:0] store_data_q [$];

  // Instruction bus model state
  logic        ireq_pending;
  int          igrant_wait;
  logic [31:0] ireq_addr;
  logic        irsp_pending;
  int          irsp_wait;
  logic [31:0] irsp_addr;
  logic [31:0] next_fetch_addr;
  int          fetch_count;

  // Data bus model state
  logic        dreq_pending;
  int          dgrant_wait;
  logic [31:0] dreq_addr;
  logic [31:0] dreq_data;

  always #5 clk_i = ~clk_i;

  core_top UUT (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .data_req_o     ( data_req_o     ),
    .data_gnt_i     ( data_gnt_i     ),
    .data_addr_o    ( data_addr_o    ),
    .data_wdata_o   ( data_wdata_o   )
  );

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and checks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure(string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic compare_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected) begin
      stop_with_failure($sformatf("mismatch at %0t ns: %s expected 0x%08h actual 0x%08h",
                                  $time, name, expected, actual));
    end
  endtask

  // Both bus requests low
  task automatic expect_buses_idle();
    compare_value("instr_req_o", 32'd0, 32'(instr_req_o));
    compare_value("data_req_o", 32'd0, 32'(data_req_o));
  endtask

  //////////////////////////////////////////////////////////////////////
  // RV32I encoders
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] itype_word(logic [11:0] imm, logic [4:0] rs1,
                                             logic [2:0] funct3, logic [4:0] rd,
                                             logic [6:0] opcode);
    return {imm, rs1, funct3, rd, opcode};
  endfunction

  function automatic logic [31:0] rtype_word(logic [6:0] funct7, logic [4:0] rs2,
                                             logic [4:0] rs1, logic [2:0] funct3,
                                             logic [4:0] rd);
    return {funct7, rs2, rs1, funct3, rd, core_isa_pkg::OP};
  endfunction

  // sw rs2, imm(rs1)
  function automatic logic [31:0] stype_word(logic [11:0] imm, logic [4:0] rs2,
                                             logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, core_isa_pkg::F3_SW, imm[4:0], core_isa_pkg::STORE};
  endfunction

  function automatic logic [31:0] utype_word(logic [19:0] imm, logic [4:0] rd);
    return {imm, rd, core_isa_pkg::LUI};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Program and expected store tables
  //////////////////////////////////////////////////////////////////////

  task automatic build_program();
    // Chained immediates, x2 forwarded from x1 and into the store
    prog_q.push_back(itype_word(12'h123, 5'd0, core_isa_pkg::F3_ADD_SUB, 5'd1,
                                core_isa_pkg::OP_IMM));
    prog_q.push_back(itype_word(12'h011, 5'd1, core_isa_pkg::F3_ADD_SUB, 5'd2,
                                core_isa_pkg::OP_IMM));
    prog_q.push_back(stype_word(12'h100, 5'd2, 5'd0));
    // Logic immediates, x3 = -1
    prog_q.push_back(itype_word(12'hFFF, 5'd0, core_isa_pkg::F3_ADD_SUB, 5'd3,
                                core_isa_pkg::OP_IMM));
    prog_q.push_back(itype_word(12'h0F0, 5'd3, core_isa_pkg::F3_AND, 5'd4,
                                core_isa_pkg::OP_IMM));
    prog_q.push_back(itype_word(12'h00F, 5'd4, core_isa_pkg::F3_OR, 5'd5,
                                core_isa_pkg::OP_IMM));
    prog_q.push_back(itype_word(12'h7FF, 5'd5, core_isa_pkg::F3_XOR, 5'd6,
                                core_isa_pkg::OP_IMM));
    prog_q.push_back(stype_word(12'h104, 5'd6, 5'd0));
    // LUI and register ops
    prog_q.push_back(utype_word(20'hABCDE, 5'd7));
    prog_q.push_back(rtype_word(core_isa_pkg::FUNCT7_BASE, 5'd1, 5'd7,
                                core_isa_pkg::F3_ADD_SUB, 5'd8));
    prog_q.push_back(stype_word(12'h108, 5'd8, 5'd0));
    prog_q.push_back(rtype_word(core_isa_pkg::FUNCT7_SUB, 5'd2, 5'd1,
                                core_isa_pkg::F3_ADD_SUB, 5'd9));
    prog_q.push_back(stype_word(12'h10C, 5'd9, 5'd0));
    prog_q.push_back(rtype_word(core_isa_pkg::FUNCT7_BASE, 5'd3, 5'd7,
                                core_isa_pkg::F3_AND, 5'd10));
    prog_q.push_back(rtype_word(core_isa_pkg::FUNCT7_BASE, 5'd5, 5'd10,
                                core_isa_pkg::F3_OR, 5'd11));
    prog_q.push_back(rtype_word(core_isa_pkg::FUNCT7_BASE, 5'd8, 5'd11,
                                core_isa_pkg::F3_XOR, 5'd12));
    // Back-to-back stores
    prog_q.push_back(stype_word(12'h110, 5'd12, 5'd0));
    prog_q.push_back(stype_word(12'h114, 5'd11, 5'd0));
    // Write to x0 then store x0
    prog_q.push_back(itype_word(12'h055, 5'd1, core_isa_pkg::F3_ADD_SUB, 5'd0,
                                core_isa_pkg::OP_IMM));
    prog_q.push_back(stype_word(12'h118, 5'd0, 5'd0));
    // Unsupported: slli, lw, mul, all-ones word
    prog_q.push_back(itype_word(12'h003, 5'd1, 3'b001, 5'd1, core_isa_pkg::OP_IMM));
    prog_q.push_back(itype_word(12'h000, 5'd0, core_isa_pkg::F3_SW, 5'd2, OPC_LOAD));
    prog_q.push_back(rtype_word(7'b000_0001, 5'd2, 5'd1, core_isa_pkg::F3_ADD_SUB, 5'd3));
    prog_q.push_back(32'hFFFF_FFFF);
    // x1, x2, x3 and x31 untouched by the above
    prog_q.push_back(stype_word(12'h11C, 5'd1, 5'd0));
    prog_q.push_back(stype_word(12'h120, 5'd2, 5'd0));
    prog_q.push_back(stype_word(12'h124, 5'd3, 5'd0));
    prog_q.push_back(stype_word(12'h128, 5'd31, 5'd0));
    // Negative store offset off a forwarded base
    prog_q.push_back(itype_word(12'h200, 5'd0, core_isa_pkg::F3_ADD_SUB, 5'd13,
                                core_isa_pkg::OP_IMM));
    prog_q.push_back(stype_word(12'hFF8, 5'd5, 5'd13));
    prog_q.push_back(rtype_word(core_isa_pkg::FUNCT7_SUB, 5'd6, 5'd13,
                                core_isa_pkg::F3_ADD_SUB, 5'd14));
    prog_q.push_back(stype_word(12'h7FC, 5'd14, 5'd0));
  endtask

  // Worked out by hand, in program order
  task automatic expected_stores_init();
    exp_addr_q = '{32'h0000_0100, 32'h0000_0104, 32'h0000_0108, 32'h0000_010C,
                   32'h0000_0110, 32'h0000_0114, 32'h0000_0118, 32'h0000_011C,
                   32'h0000_0120, 32'h0000_0124, 32'h0000_0128, 32'h0000_01F8,
                   32'h0000_07FC};
    exp_data_q = '{32'h0000_0134, 32'h0000_0700, 32'hABCD_E123, 32'hFFFF_FFEF,
                   32'h0000_01DC, 32'hABCD_E0FF, 32'h0000_0000, 32'h0000_0123,
                   32'h0000_0134, 32'hFFFF_FFFF, 32'h0000_0000, 32'h0000_00FF,
                   32'hFFFF_FB00};
  endtask

  // Program word for an address, NOP outside the program
  function automatic logic [31:0] fetch_word(logic [31:0] addr);
    logic [31:0] offset;
    int          idx;
    offset = addr - BOOT_ADDR;
    idx    = int'(offset >> 2);
    if ((offset[1:0] == 2'b00) && (idx < prog_q.size())) begin
      return prog_q[idx];
    end else begin
      return `CORE_NOP;
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Instruction bus model
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    instr_gnt_i    <= 1'b0;
    instr_rvalid_i <= 1'b0;
    if (!rst_n_i) begin
      ireq_pending    = 1'b0;
      irsp_pending    = 1'b0;
      next_fetch_addr = BOOT_ADDR;
      fetch_count     = 0;
    end else if (irsp_pending) begin
      // One fetch outstanding at most
      if (instr_req_o) begin
        stop_with_failure("instruction request made while a fetch is still outstanding");
      end
      irsp_wait = irsp_wait - 1;
      if (irsp_wait == 0) begin
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= fetch_word(irsp_addr);
        irsp_pending    = 1'b0;
      end
    end else if (instr_req_o) begin
      if (!ireq_pending) begin
        // New request, address must follow the sequence
        compare_value("instr_addr_o", next_fetch_addr, instr_addr_o);
        ireq_pending = 1'b1;
        ireq_addr    = instr_addr_o;
        igrant_wait  = $urandom % 4;
      end else begin
        compare_value("instr_addr_o", ireq_addr, instr_addr_o);
      end
      if (igrant_wait == 0) begin
        instr_gnt_i    <= 1'b1;
        ireq_pending    = 1'b0;
        irsp_pending    = 1'b1;
        irsp_wait       = 1 + ($urandom % 3);
        irsp_addr       = ireq_addr;
        next_fetch_addr = ireq_addr + 32'd4;
        fetch_count     = fetch_count + 1;
      end else begin
        igrant_wait = igrant_wait - 1;
      end
    end else if (ireq_pending) begin
      stop_with_failure("instruction request withdrawn before it was granted");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Data bus model
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    data_gnt_i <= 1'b0;
    if (!rst_n_i) begin
      dreq_pending = 1'b0;
    end else if (data_req_o) begin
      if (!dreq_pending) begin
        dreq_pending = 1'b1;
        dreq_addr    = data_addr_o;
        dreq_data    = data_wdata_o;
        dgrant_wait  = $urandom % 4;
      end else begin
        // Held stable until grant
        compare_value("data_addr_o", dreq_addr, data_addr_o);
        compare_value("data_wdata_o", dreq_data, data_wdata_o);
      end
      if (dgrant_wait == 0) begin
        data_gnt_i  <= 1'b1;
        dreq_pending = 1'b0;
        store_addr_q.push_back(dreq_addr);
        store_data_q.push_back(dreq_data);
      end else begin
        dgrant_wait = dgrant_wait - 1;
      end
    end else if (dreq_pending) begin
      stop_with_failure("data request withdrawn before it was granted");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Waits
  //////////////////////////////////////////////////////////////////////

  task automatic await_store(int idx);
    int cycles;
    cycles = 0;
    while (store_addr_q.size() <= idx) begin
      if (cycles >= STORE_TIMEOUT) begin
        stop_with_failure($sformatf("timed out waiting for store number %0d", idx));
      end else begin
        @(negedge clk_i);
        cycles = cycles + 1;
      end
    end
  endtask

  task automatic drain_fetches(int target);
    int cycles;
    cycles = 0;
    while (fetch_count < target) begin
      if (cycles >= FETCH_TIMEOUT) begin
        stop_with_failure("timed out waiting for fetches past the end of the program");
      end else begin
        @(negedge clk_i);
        cycles = cycles + 1;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    rst_n_i        = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    build_program();
    expected_stores_init();

    // Four reset cycles, buses quiet
    repeat (4) begin
      @(negedge clk_i);
      expect_buses_idle();
    end
    rst_n_i <= 1'b1;

    // Out of reset, fetch still off
    repeat (3) begin
      @(negedge clk_i);
      expect_buses_idle();
    end
    fetch_enable_i <= 1'b1;

    // First request the cycle after enable
    @(negedge clk_i);
    compare_value("instr_req_o", 32'd1, 32'(instr_req_o));
    compare_value("instr_addr_o", BOOT_ADDR, instr_addr_o);

    for (int i = 0; i < exp_addr_q.size(); i++) begin
      await_store(i);
      compare_value($sformatf("data_addr_o of store %0d", i), exp_addr_q[i], store_addr_q[i]);
      compare_value($sformatf("data_wdata_o of store %0d", i), exp_data_q[i], store_data_q[i]);
    end

    // Nothing extra once the program has drained
    drain_fetches(prog_q.size() + DRAIN_WORDS);
    compare_value("store count", 32'(exp_addr_q.size()), 32'(store_addr_q.size()));

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* design/core_top.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module core_top (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  input  logic                  fetch_enable_i,
  input  logic [`CORE_XLEN-1:0] boot_addr_i,

  // Instruction bus
  output logic                  instr_req_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  output logic [`CORE_XLEN-1:0] instr_addr_o,
  input  logic [`CORE_XLEN-1:0] instr_rdata_i,

  // Data bus
  output logic                  data_req_o,
  input  logic                  data_gnt_i,
  output logic [`CORE_XLEN-1:0] data_addr_o,
  output logic [`CORE_XLEN-1:0] data_wdata_o
);

  // IF to IF/ID register
  logic                       if_valid;
  logic                       if_ready;
  core_pipe_pkg::if_id_pipe_t if_id_d;

  // IF/ID register to decode and ID/EX register
  logic                       id_valid;
  logic                       id_ready;
  core_pipe_pkg::if_id_pipe_t if_id_q;
  core_pipe_pkg::id_ex_pipe_t id_ex_d;

  // ID/EX register to execute
  logic                       ex_valid;
  logic                       ex_ready;
  core_pipe_pkg::id_ex_pipe_t id_ex_q;

  // Register file
  logic [`CORE_REG_AW-1:0]    rf_raddr_a;
  logic [`CORE_REG_AW-1:0]    rf_raddr_b;
  logic [`CORE_XLEN-1:0]      rf_rdata_a;
  logic [`CORE_XLEN-1:0]      rf_rdata_b;
  logic                       rf_we;
  logic [`CORE_REG_AW-1:0]    rf_waddr;
  logic [`CORE_XLEN-1:0]      rf_wdata;

  //////////////////////////////////////////////////////////////////////
  // Fetch
  //////////////////////////////////////////////////////////////////////

  core_if_stage if_stage_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .if_valid_o     ( if_valid       ),
    .if_ready_i     ( if_ready       ),
    .if_id_o        ( if_id_d        )
  );

  core_pipe_reg #(
    .payload_t ( core_pipe_pkg::if_id_pipe_t )
  ) if_id_reg_i (
    .clk_i     ( clk_i    ),
    .rst_n_i   ( rst_n_i  ),
    .valid_i   ( if_valid ),
    .ready_o   ( if_ready ),
    .payload_i ( if_id_d  ),
    .valid_o   ( id_valid ),
    .ready_i   ( id_ready ),
    .payload_o ( if_id_q  )
  );

  //////////////////////////////////////////////////////////////////////
  // Decode and register file
  //////////////////////////////////////////////////////////////////////

  // Decode is pure logic between the two registers
  core_id_stage id_stage_i (
    .if_id_i      ( if_id_q    ),
    .rf_raddr_a_o ( rf_raddr_a ),
    .rf_raddr_b_o ( rf_raddr_b ),
    .rf_rdata_a_i ( rf_rdata_a ),
    .rf_rdata_b_i ( rf_rdata_b ),
    .ex_rf_we_i   ( rf_we      ),
    .ex_rd_i      ( rf_waddr   ),
    .ex_wdata_i   ( rf_wdata   ),
    .id_ex_o      ( id_ex_d    )
  );

  core_register_file register_file_i (
    .clk_i     ( clk_i      ),
    .rst_n_i   ( rst_n_i    ),
    .raddr_a_i ( rf_raddr_a ),
    .raddr_b_i ( rf_raddr_b ),
    .rdata_a_o ( rf_rdata_a ),
    .rdata_b_o ( rf_rdata_b ),
    .we_i      ( rf_we      ),
    .waddr_i   ( rf_waddr   ),
    .wdata_i   ( rf_wdata   )
  );

  core_pipe_reg #(
    .payload_t ( core_pipe_pkg::id_ex_pipe_t )
  ) id_ex_reg_i (
    .clk_i     ( clk_i    ),
    .rst_n_i   ( rst_n_i  ),
    .valid_i   ( id_valid ),
    .ready_o   ( id_ready ),
    .payload_i ( id_ex_d  ),
    .valid_o   ( ex_valid ),
    .ready_i   ( ex_ready ),
    .payload_o ( id_ex_q  )
  );

  //////////////////////////////////////////////////////////////////////
  // Execute and writeback
  //////////////////////////////////////////////////////////////////////

  core_ex_stage ex_stage_i (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .ex_valid_i   ( ex_valid     ),
    .ex_ready_o   ( ex_ready     ),
    .id_ex_i      ( id_ex_q      ),
    .rf_we_o      ( rf_we        ),
    .rf_waddr_o   ( rf_waddr     ),
    .rf_wdata_o   ( rf_wdata     ),
    .data_req_o   ( data_req_o   ),
    .data_addr_o  ( data_addr_o  ),
    .data_wdata_o ( data_wdata_o ),
    .data_gnt_i   ( data_gnt_i   )
  );

endmodule

/* design/core_ex_stage.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module core_ex_stage (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  // From the ID/EX register
  input  logic                        ex_valid_i,
  output logic                        ex_ready_o,
  input  core_pipe_pkg::id_ex_pipe_t  id_ex_i,

  // Register file write port, also forwarded to decode
  output logic                        rf_we_o,
  output logic [`CORE_REG_AW-1:0]     rf_waddr_o,
  output logic [`CORE_XLEN-1:0]       rf_wdata_o,

  // Data bus, word writes only
  output logic                        data_req_o,
  output logic [`CORE_XLEN-1:0]       data_addr_o,
  output logic [`CORE_XLEN-1:0]       data_wdata_o,
  input  logic                        data_gnt_i
);

  logic [`CORE_XLEN-1:0] alu_result;

  ////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    case (id_ex_i.alu_op)
      core_pipe_pkg::ALU_SUB:    alu_result = id_ex_i.operand_a - id_ex_i.operand_b;
      core_pipe_pkg::ALU_AND:    alu_result = id_ex_i.operand_a & id_ex_i.operand_b;
      core_pipe_pkg::ALU_OR:     alu_result = id_ex_i.operand_a | id_ex_i.operand_b;
      core_pipe_pkg::ALU_XOR:    alu_result = id_ex_i.operand_a ^ id_ex_i.operand_b;
      core_pipe_pkg::ALU_PASS_B: alu_result = id_ex_i.operand_b;
      default:                   alu_result = id_ex_i.operand_a + id_ex_i.operand_b;
    endcase
  end

  // ALU items leave in their first cycle, so each writes once
  assign rf_we_o    = ex_valid_i && id_ex_i.rf_we;
  assign rf_waddr_o = id_ex_i.rd;
  assign rf_wdata_o = alu_result;

  ////////////////////////////////////////////////////////////////////
  // Store issue
  ////////////////////////////////////////////////////////////////////

  // Held by the ID/EX register, so stable until grant
  assign data_req_o   = ex_valid_i && id_ex_i.is_store;
  assign data_addr_o  = alu_result;
  assign data_wdata_o = id_ex_i.store_data;

  // Grant completes the store
  assign ex_ready_o = !data_req_o || data_gnt_i;

endmodule

/* design/core_id_stage.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module core_id_stage (
  // From the IF/ID register
  input  core_pipe_pkg::if_id_pipe_t  if_id_i,

  // Register file read ports
  output logic [`CORE_REG_AW-1:0]     rf_raddr_a_o,
  output logic [`CORE_REG_AW-1:0]     rf_raddr_b_o,
  input  logic [`CORE_XLEN-1:0]       rf_rdata_a_i,
  input  logic [`CORE_XLEN-1:0]       rf_rdata_b_i,

  // Writeback from execute, for forwarding
  input  logic                        ex_rf_we_i,
  input  logic [`CORE_REG_AW-1:0]     ex_rd_i,
  input  logic [`CORE_XLEN-1:0]       ex_wdata_i,

  // Towards the ID/EX register
  output core_pipe_pkg::id_ex_pipe_t  id_ex_o
);

  logic [`CORE_XLEN-1:0]   instr;
  logic [6:0]              opcode;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [`CORE_REG_AW-1:0] rs1;
  logic [`CORE_REG_AW-1:0] rs2;
  logic [`CORE_REG_AW-1:0] rd;
  logic [`CORE_XLEN-1:0]   imm_i;
  logic [`CORE_XLEN-1:0]   imm_s;
  logic [`CORE_XLEN-1:0]   imm_u;
  logic [`CORE_XLEN-1:0]   rs1_data;
  logic [`CORE_XLEN-1:0]   rs2_data;
  logic                    we_raw;

  ////////////////////////////////////////////////////////////////////
  // Field extraction
  ////////////////////////////////////////////////////////////////////

  assign instr  = if_id_i.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign rd     = instr[11:7];

  // Sign-extended I and S, LUI shifted up
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'b0};

  assign rf_raddr_a_o = rs1;
  assign rf_raddr_b_o = rs2;

  // Execute writes this cycle, so its result beats the register file
  assign rs1_data = (ex_rf_we_i && (ex_rd_i == rs1)) ? ex_wdata_i : rf_rdata_a_i;
  assign rs2_data = (ex_rf_we_i && (ex_rd_i == rs2)) ? ex_wdata_i : rf_rdata_b_i;

  ////////////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    id_ex_o.alu_op     = core_pipe_pkg::ALU_ADD;
    id_ex_o.operand_a  = rs1_data;
    id_ex_o.operand_b  = rs2_data;
    id_ex_o.store_data = rs2_data;
    id_ex_o.rd         = rd;
    id_ex_o.is_store   = 1'b0;
    we_raw             = 1'b0;

    case (opcode)
      core_isa_pkg::OP_IMM: begin
        id_ex_o.operand_b = imm_i;
        we_raw            = 1'b1;
        case (funct3)
          core_isa_pkg::F3_ADD_SUB: id_ex_o.alu_op = core_pipe_pkg::ALU_ADD;
          core_isa_pkg::F3_AND:     id_ex_o.alu_op = core_pipe_pkg::ALU_AND;
          core_isa_pkg::F3_OR:      id_ex_o.alu_op = core_pipe_pkg::ALU_OR;
          core_isa_pkg::F3_XOR:     id_ex_o.alu_op = core_pipe_pkg::ALU_XOR;
          // Shifts and compares are not kept
          default:                  we_raw = 1'b0;
        endcase
      end
      core_isa_pkg::OP: begin
        we_raw = (funct7 == core_isa_pkg::FUNCT7_BASE);
        case (funct3)
          core_isa_pkg::F3_ADD_SUB: begin
            if (funct7 == core_isa_pkg::FUNCT7_SUB) begin
              id_ex_o.alu_op = core_pipe_pkg::ALU_SUB;
              we_raw         = 1'b1;
            end
          end
          core_isa_pkg::F3_AND:     id_ex_o.alu_op = core_pipe_pkg::ALU_AND;
          core_isa_pkg::F3_OR:      id_ex_o.alu_op = core_pipe_pkg::ALU_OR;
          core_isa_pkg::F3_XOR:     id_ex_o.alu_op = core_pipe_pkg::ALU_XOR;
          default:                  we_raw = 1'b0;
        endcase
      end
      core_isa_pkg::LUI: begin
        id_ex_o.alu_op    = core_pipe_pkg::ALU_PASS_B;
        id_ex_o.operand_b = imm_u;
        we_raw            = 1'b1;
      end
      core_isa_pkg::STORE: begin
        // Word stores only, other widths fall through as no-ops
        id_ex_o.operand_b = imm_s;
        id_ex_o.is_store  = (funct3 == core_isa_pkg::F3_SW);
      end
      default: begin
        we_raw = 1'b0;
      end
    endcase

    // x0 is never written
    id_ex_o.rf_we = we_raw && (rd != '0);
  end

endmodule

/* design/core_if_stage.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module core_if_stage (
  input  logic                        clk_i,
  input  logic                        rst_n_i,

  input  logic                        fetch_enable_i,
  input  logic [`CORE_XLEN-1:0]       boot_addr_i,

  // Instruction bus
  output logic                        instr_req_o,
  output logic [`CORE_XLEN-1:0]       instr_addr_o,
  input  logic                        instr_gnt_i,
  input  logic                        instr_rvalid_i,
  input  logic [`CORE_XLEN-1:0]       instr_rdata_i,

  // Towards the IF/ID register
  output logic                        if_valid_o,
  input  logic                        if_ready_i,
  output core_pipe_pkg::if_id_pipe_t  if_id_o
);

  typedef enum logic [1:0] {
    IF_IDLE,
    IF_REQ,
    IF_WAIT_RSP,
    IF_HOLD
  } if_state_e;

  if_state_e             state_q;
  logic                  fetch_en_q;
  logic                  fetch_en_d;
  logic [`CORE_XLEN-1:0] pc_q;
  logic [`CORE_XLEN-1:0] instr_q;
  logic                  rsp_taken;

  // Sticky fetch enable, the live input counts in the same cycle
  assign fetch_en_d = fetch_en_q || fetch_enable_i;

  assign instr_req_o  = (state_q == IF_REQ);
  assign instr_addr_o = pc_q;

  // Response goes straight out, or from the hold register later
  assign if_valid_o = (state_q == IF_HOLD) || ((state_q == IF_WAIT_RSP) && instr_rvalid_i);
  assign rsp_taken  = if_valid_o && if_ready_i;

  // pc_q already points past the granted fetch
  assign if_id_o.instr = (state_q == IF_HOLD) ? instr_q : instr_rdata_i;
  assign if_id_o.pc    = pc_q - `CORE_XLEN'd4;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= IF_IDLE;
      fetch_en_q <= 1'b0;
      pc_q       <= `CORE_PC_RESET;
      instr_q    <= `CORE_NOP;
    end else begin
      fetch_en_q <= fetch_en_d;
      case (state_q)
        IF_IDLE: begin
          pc_q <= boot_addr_i;
          if (fetch_en_d) begin
            state_q <= IF_REQ;
          end
        end
        IF_REQ: begin
          // Address advances at grant
          if (instr_gnt_i) begin
            pc_q    <= pc_q + `CORE_XLEN'd4;
            state_q <= IF_WAIT_RSP;
          end
        end
        IF_WAIT_RSP: begin
          if (instr_rvalid_i) begin
            instr_q <= instr_rdata_i;
            if (!rsp_taken) begin
              state_q <= IF_HOLD;
            end else begin
              // Enable is sticky, fetching carries on
              state_q <= IF_REQ;
            end
          end
        end
        default: begin
          // IF_HOLD, wait for the IF/ID register
          if (rsp_taken) begin
            state_q <= IF_REQ;
          end
        end
      endcase
    end
  end

endmodule

/* design/core_pipe_pkg.sv */
`include "core_consts.svh"

package core_pipe_pkg;

  // ALU operations
  // PASS_B forwards operand B, used by LUI
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_e;

  // IF/ID payload
  typedef struct packed {
    logic [`CORE_XLEN-1:0] instr;
    logic [`CORE_XLEN-1:0] pc;
  } if_id_pipe_t;

  // ID/EX payload
  typedef struct packed {
    alu_op_e                 alu_op;
    logic [`CORE_XLEN-1:0]   operand_a;
    logic [`CORE_XLEN-1:0]   operand_b;
    // Store data, already forwarded
    logic [`CORE_XLEN-1:0]   store_data;
    logic [`CORE_REG_AW-1:0] rd;
    logic                    rf_we;
    logic                    is_store;
  } id_ex_pipe_t;

endpackage

/* design/core_isa_pkg.sv */
package core_isa_pkg;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OP_IMM = 7'b001_0011,
    OP     = 7'b011_0011,
    LUI    = 7'b011_0111,
    STORE  = 7'b010_0011
  } opcode_e;

  // Function selectors
  // ADD and SUB share one code, funct7 tells them apart
  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'b000,
    F3_SW      = 3'b010,
    F3_XOR     = 3'b100,
    F3_OR      = 3'b110,
    F3_AND     = 3'b111
  } funct3_e;

  // funct7 for plain register ops
  localparam logic [6:0] FUNCT7_BASE = 7'b000_0000;

  // funct7 marking SUB
  localparam logic [6:0] FUNCT7_SUB  = 7'b010_0000;

endpackage

/* design/core_register_file.sv */
`timescale 1ns/10ps
`include "core_consts.svh"

module core_register_file (
  input  logic                    clk_i,
  input  logic                    rst_n_i,

  // Read ports
  input  logic [`CORE_REG_AW-1:0] raddr_a_i,
  input  logic [`CORE_REG_AW-1:0] raddr_b_i,
  output logic [`CORE_XLEN-1:0]   rdata_a_o,
  output logic [`CORE_XLEN-1:0]   rdata_b_o,

  // Write port
  input  logic                    we_i,
  input  logic [`CORE_REG_AW-1:0] waddr_i,
  input  logic [`CORE_XLEN-1:0]   wdata_i
);

  logic [`CORE_XLEN-1:0] regs_q [`CORE_NUM_REGS];

  // All registers clear on reset
  // x0 holds zero since decode never targets it
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `CORE_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Combinational reads
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];

endmodule

/* design/core_pipe_reg.sv */
`timescale 1ns/10ps

module core_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,

  // Upstream side
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t payload_i,

  // Downstream side
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t payload_o
);

  logic     valid_q;
  payload_t payload_q;

  // Accept when empty or when the held item leaves this cycle
  assign ready_o = !valid_q || ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload only moves on a transfer
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      payload_q <= payload_i;
    end
  end

  assign valid_o   = valid_q;
  assign payload_o = payload_q;

endmodule

/* design/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// Data path and address width
`define CORE_XLEN 32

// Architectural integer registers
`define CORE_NUM_REGS 32

// Register index width
`define CORE_REG_AW 5

// Canonical no-op, addi x0, x0, 0
`define CORE_NOP 32'h0000_0013

// Reset value of the program counter before boot_addr_i is loaded
`define CORE_PC_RESET 32'h0000_0000

`endif
